// File: source/soc_bus_cfg.svh
// system bus config: widths, address map, memory depths and slave constants
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// bus widths
`define SB_ADR_W 32
`define SB_DAT_W 32
`define SB_SEL_W 4

// memory depths in words
`define RAM_WORDS 1024
`define ROM_WORDS 32

// top address byte per region
`define RAM_REGION 8'h00
`define ETH_REGION 8'h92
`define DS1_REGION 8'hc0
`define DS2_REGION 8'he0
`define ROM_REGION 8'hf0

`define DS1_VALUE 32'hc0000000
`define DS2_VALUE 32'hf0000000
`define ROM_WORD_BASE 32'h15000000 // l.nop pattern, index goes in low bits

`endif

// File: source/soc_bus_pkg.sv
// system bus types: decoder target select and arbiter master index
package soc_bus_pkg;

   // decoder target, one per region plus the miss case
   typedef enum logic [2:0] {
      SEL_RAM,
      SEL_ETH,
      SEL_DS1,
      SEL_DS2,
      SEL_ROM,
      SEL_NONE
   } slave_sel_e;

   // bus owner
   typedef enum logic {
      M_DATA,  // processor data port
      M_DEBUG  // debug unit
   } master_e;

endpackage

// File: source/wb_if.sv
// wishbone classic bus bundle between masters, arbiter, decoder and slaves
`include "soc_bus_cfg.svh"

interface wb_if;
   logic [`SB_ADR_W-1:0] adr;
   logic [`SB_DAT_W-1:0] dat_w;
   logic [`SB_DAT_W-1:0] dat_r;
   logic [`SB_SEL_W-1:0] sel;
   logic                 we;
   logic                 cyc;
   logic                 stb;
   logic                 ack;
   logic                 err;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack, err
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack, err
   );

   // observation only
   modport monitor (
      input adr, dat_w, dat_r, sel, we, cyc, stb, ack, err
   );

endinterface

// File: source/wb_arbiter.sv
// two-master round-robin arbiter onto the shared system bus
`include "soc_bus_cfg.svh"

module wb_arbiter (
   input  logic wb_clk,
   input  logic rst_n_i,
   wb_if.slave  m_data,
   wb_if.slave  m_debug,
   wb_if.master bus
);

   soc_bus_pkg::master_e owner_q, owner_d;
   soc_bus_pkg::master_e last_q; // master whose transfer ended last
   logic gnt_q, gnt_d;
   logic own_data, own_debug;
   logic owner_cyc;

   assign own_data  = gnt_q & (owner_q == soc_bus_pkg::M_DATA);
   assign own_debug = gnt_q & (owner_q == soc_bus_pkg::M_DEBUG);
   assign owner_cyc = (owner_q == soc_bus_pkg::M_DEBUG) ? m_debug.cyc : m_data.cyc;

   always_comb begin
      owner_d = owner_q;
      gnt_d   = gnt_q;
      // hold while the owner keeps cyc up, otherwise rearbitrate
      if (!(gnt_q && owner_cyc)) begin
         gnt_d = m_data.cyc | m_debug.cyc;
         if (m_data.cyc && m_debug.cyc) begin
            owner_d = (last_q == soc_bus_pkg::M_DATA) ? soc_bus_pkg::M_DEBUG
                                                       : soc_bus_pkg::M_DATA;
         end else if (m_debug.cyc) begin
            owner_d = soc_bus_pkg::M_DEBUG;
         end else if (m_data.cyc) begin
            owner_d = soc_bus_pkg::M_DATA;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         gnt_q   <= 1'b0;
         owner_q <= soc_bus_pkg::M_DATA;
         last_q  <= soc_bus_pkg::M_DEBUG; // data port wins the first tie
      end else begin
         gnt_q   <= gnt_d;
         owner_q <= owner_d;
         if (gnt_q && (bus.ack || bus.err))
            last_q <= owner_q;
      end
   end

   // request path from the owner
   assign bus.adr   = own_debug ? m_debug.adr   : m_data.adr;
   assign bus.dat_w = own_debug ? m_debug.dat_w : m_data.dat_w;
   assign bus.sel   = own_debug ? m_debug.sel   : m_data.sel;
   assign bus.we    = own_debug ? m_debug.we    : m_data.we;
   assign bus.cyc   = gnt_q & owner_cyc;
   assign bus.stb   = own_debug ? m_debug.stb : (own_data & m_data.stb);

   // responses only reach the owner
   assign m_data.dat_r  = own_data ? bus.dat_r : '0;
   assign m_data.ack    = own_data & bus.ack;
   assign m_data.err    = own_data & bus.err;
   assign m_debug.dat_r = own_debug ? bus.dat_r : '0;
   assign m_debug.ack   = own_debug & bus.ack;
   assign m_debug.err   = own_debug & bus.err;

endmodule

// File: source/wb_decoder.sv
// address decoder that routes the granted transfer to one slave and answers misses
`include "soc_bus_cfg.svh"

module wb_decoder (
   input  logic wb_clk,
   input  logic rst_n_i,
   wb_if.slave  bus,
   wb_if.master ram_bus,
   wb_if.master rom_bus,
   wb_if.master ds1_bus,
   wb_if.master ds2_bus
);

   soc_bus_pkg::slave_sel_e tgt;
   logic                 req;
   logic                 eth_ack_q; // ethernet config stub
   logic                 err_q;
   logic [`SB_DAT_W-1:0] dat_mux;
   logic                 ack_mux;
   logic                 err_mux;

   always_comb begin
      case (bus.adr[`SB_ADR_W-1 -: 8])
         `RAM_REGION: tgt = soc_bus_pkg::SEL_RAM;
         `ETH_REGION: tgt = soc_bus_pkg::SEL_ETH;
         `DS1_REGION: tgt = soc_bus_pkg::SEL_DS1;
         `DS2_REGION: tgt = soc_bus_pkg::SEL_DS2;
         `ROM_REGION: tgt = soc_bus_pkg::SEL_ROM;
         default:     tgt = soc_bus_pkg::SEL_NONE;
      endcase
   end

   assign req = bus.cyc & bus.stb;

   // strobes go to the selected slave only
   assign ram_bus.cyc = bus.cyc & (tgt == soc_bus_pkg::SEL_RAM);
   assign ram_bus.stb = bus.stb & (tgt == soc_bus_pkg::SEL_RAM);
   assign rom_bus.cyc = bus.cyc & (tgt == soc_bus_pkg::SEL_ROM);
   assign rom_bus.stb = bus.stb & (tgt == soc_bus_pkg::SEL_ROM);
   assign ds1_bus.cyc = bus.cyc & (tgt == soc_bus_pkg::SEL_DS1);
   assign ds1_bus.stb = bus.stb & (tgt == soc_bus_pkg::SEL_DS1);
   assign ds2_bus.cyc = bus.cyc & (tgt == soc_bus_pkg::SEL_DS2);
   assign ds2_bus.stb = bus.stb & (tgt == soc_bus_pkg::SEL_DS2);

   assign ram_bus.adr   = bus.adr;
   assign ram_bus.dat_w = bus.dat_w;
   assign ram_bus.sel   = bus.sel;
   assign ram_bus.we    = bus.we;
   assign rom_bus.adr   = bus.adr;
   assign rom_bus.dat_w = bus.dat_w;
   assign rom_bus.sel   = bus.sel;
   assign rom_bus.we    = bus.we;
   assign ds1_bus.adr   = bus.adr;
   assign ds1_bus.dat_w = bus.dat_w;
   assign ds1_bus.sel   = bus.sel;
   assign ds1_bus.we    = bus.we;
   assign ds2_bus.adr   = bus.adr;
   assign ds2_bus.dat_w = bus.dat_w;
   assign ds2_bus.sel   = bus.sel;
   assign ds2_bus.we    = bus.we;

   // eth stub acks and drops writes while a miss gets a one-cycle err
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         eth_ack_q <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         eth_ack_q <= req & (tgt == soc_bus_pkg::SEL_ETH) & ~eth_ack_q;
         err_q     <= req & (tgt == soc_bus_pkg::SEL_NONE) & ~err_q;
      end
   end

   always_comb begin
      dat_mux = '0; // eth reads as zero
      ack_mux = eth_ack_q;
      err_mux = err_q;
      case (tgt)
         soc_bus_pkg::SEL_RAM: begin
            dat_mux = ram_bus.dat_r;
            ack_mux = ram_bus.ack;
            err_mux = ram_bus.err;
         end
         soc_bus_pkg::SEL_ROM: begin
            dat_mux = rom_bus.dat_r;
            ack_mux = rom_bus.ack;
            err_mux = rom_bus.err;
         end
         soc_bus_pkg::SEL_DS1: begin
            dat_mux = ds1_bus.dat_r;
            ack_mux = ds1_bus.ack;
            err_mux = ds1_bus.err;
         end
         soc_bus_pkg::SEL_DS2: begin
            dat_mux = ds2_bus.dat_r;
            ack_mux = ds2_bus.ack;
            err_mux = ds2_bus.err;
         end
         default: ;
      endcase
   end

   assign bus.dat_r = dat_mux;
   assign bus.ack   = ack_mux;
   assign bus.err   = err_mux;

endmodule

// File: source/boot_rom.sv
// startup rom: table of no-op words, index carried in the low bits
`include "soc_bus_cfg.svh"

module boot_rom (
   input logic wb_clk,
   input logic rst_n_i,
   wb_if.slave bus
);

   localparam int IDX_W = $clog2(`ROM_WORDS);

   logic [IDX_W-1:0]     idx;
   logic [`SB_DAT_W-1:0] dat_q;
   logic                 ack_q;
   logic                 req;

   assign idx = bus.adr[IDX_W+1:2]; // word index
   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge wb_clk) begin
      dat_q <= `ROM_WORD_BASE | `SB_DAT_W'(idx);
   end

   // writes are acked and dropped
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= req;
   end

   assign bus.dat_r = dat_q;
   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;

endmodule

// File: source/wb_ram.sv
// on-chip ram slave with byte-lane writes and registered reads
`include "soc_bus_cfg.svh"

module wb_ram (
   input logic wb_clk,
   input logic rst_n_i,
   wb_if.slave bus
);

   localparam int AW = $clog2(`RAM_WORDS);

   logic [`SB_DAT_W-1:0] mem [0:`RAM_WORDS-1];
   logic [AW-1:0]        idx;
   logic [`SB_DAT_W-1:0] dat_q;
   logic                 ack_q;
   logic                 req;

   // upper address bits ignored, region wraps
   assign idx = bus.adr[AW+1:2];
   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge wb_clk) begin
      if (req && bus.we) begin
         for (int b = 0; b < `SB_SEL_W; b++) begin
            if (bus.sel[b])
               mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      dat_q <= mem[idx]; // whole word, sel ignored on reads
   end

   always_ff @(posedge wb_clk) begin
      if (!rst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= req;
   end

   assign bus.dat_r = dat_q;
   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;

endmodule

// File: source/const_slave.sv
// dummy slave: acks every access and reads back a fixed word
`include "soc_bus_cfg.svh"

module const_slave #(
   parameter logic [`SB_DAT_W-1:0] value = '0
) (
   input logic wb_clk,
   input logic rst_n_i,
   wb_if.slave bus
);

   logic ack_q;

   // write data is dropped
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & bus.stb & ~ack_q;
   end

   assign bus.dat_r = value;
   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;

endmodule

// File: source/soc_bus_top.sv
// soc system bus: two masters, arbiter, decoder, ram, rom and dummy slaves
`include "soc_bus_cfg.svh"

module soc_bus_top (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,

   // processor data port
   input  logic [`SB_ADR_W-1:0] m0_adr_i,
   input  logic [`SB_DAT_W-1:0] m0_dat_i,
   input  logic [`SB_SEL_W-1:0] m0_sel_i,
   input  logic                 m0_we_i,
   input  logic                 m0_cyc_i,
   input  logic                 m0_stb_i,
   output logic [`SB_DAT_W-1:0] m0_dat_o,
   output logic                 m0_ack_o,
   output logic                 m0_err_o,

   // debug unit port
   input  logic [`SB_ADR_W-1:0] m1_adr_i,
   input  logic [`SB_DAT_W-1:0] m1_dat_i,
   input  logic [`SB_SEL_W-1:0] m1_sel_i,
   input  logic                 m1_we_i,
   input  logic                 m1_cyc_i,
   input  logic                 m1_stb_i,
   output logic [`SB_DAT_W-1:0] m1_dat_o,
   output logic                 m1_ack_o,
   output logic                 m1_err_o
);

   wb_if m0_bus ();
   wb_if m1_bus ();
   wb_if sys_bus ();  // arbiter to decoder
   wb_if ram_bus ();
   wb_if rom_bus ();
   wb_if ds1_bus ();
   wb_if ds2_bus ();

   assign m0_bus.adr   = m0_adr_i;
   assign m0_bus.dat_w = m0_dat_i;
   assign m0_bus.sel   = m0_sel_i;
   assign m0_bus.we    = m0_we_i;
   assign m0_bus.cyc   = m0_cyc_i;
   assign m0_bus.stb   = m0_stb_i;
   assign m0_dat_o     = m0_bus.dat_r;
   assign m0_ack_o     = m0_bus.ack;
   assign m0_err_o     = m0_bus.err;

   assign m1_bus.adr   = m1_adr_i;
   assign m1_bus.dat_w = m1_dat_i;
   assign m1_bus.sel   = m1_sel_i;
   assign m1_bus.we    = m1_we_i;
   assign m1_bus.cyc   = m1_cyc_i;
   assign m1_bus.stb   = m1_stb_i;
   assign m1_dat_o     = m1_bus.dat_r;
   assign m1_ack_o     = m1_bus.ack;
   assign m1_err_o     = m1_bus.err;

   wb_arbiter u_arb (
      .wb_clk  (wb_clk),
      .rst_n_i (rst_n_i),
      .m_data  (m0_bus),
      .m_debug (m1_bus),
      .bus     (sys_bus)
   );

   wb_decoder u_dec (
      .wb_clk  (wb_clk),
      .rst_n_i (rst_n_i),
      .bus     (sys_bus),
      .ram_bus (ram_bus),
      .rom_bus (rom_bus),
      .ds1_bus (ds1_bus),
      .ds2_bus (ds2_bus)
   );

   wb_ram u_ram (.wb_clk(wb_clk), .rst_n_i(rst_n_i), .bus(ram_bus));

   boot_rom u_rom (.wb_clk(wb_clk), .rst_n_i(rst_n_i), .bus(rom_bus));

   const_slave #(.value(`DS1_VALUE)) u_ds1 (
      .wb_clk  (wb_clk),
      .rst_n_i (rst_n_i),
      .bus     (ds1_bus)
   );

   const_slave #(.value(`DS2_VALUE)) u_ds2 (
      .wb_clk  (wb_clk),
      .rst_n_i (rst_n_i),
      .bus     (ds2_bus)
   );

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock and reset source for the system bus
module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD = 50;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // low over three rising edges, released on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// File: sim/soc_bus_sva.sv
// protocol checks on the two master ports of the soc system bus
module soc_bus_sva (
   input logic wb_clk,
   input logic rst_n_i,
   input logic m0_cyc_i,
   input logic m0_stb_i,
   input logic m0_ack_o,
   input logic m0_err_o,
   input logic m1_cyc_i,
   input logic m1_stb_i,
   input logic m1_ack_o,
   input logic m1_err_o
);

   a_m0_one_resp: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      !(m0_ack_o && m0_err_o))
      else $error("m0 port shows ack and err in the same cycle");

   a_m1_one_resp: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      !(m1_ack_o && m1_err_o))
      else $error("m1 port shows ack and err in the same cycle");

   // single shared bus, so only one port can be answered
   a_one_port: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      !((m0_ack_o || m0_err_o) && (m1_ack_o || m1_err_o)))
      else $error("both master ports answered in the same cycle");

   a_m0_ack_req: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      m0_ack_o |-> $past(m0_cyc_i && m0_stb_i))
      else $error("m0 ack without a request in the previous cycle");

   a_m1_ack_req: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      m1_ack_o |-> $past(m1_cyc_i && m1_stb_i))
      else $error("m1 ack without a request in the previous cycle");

endmodule

bind soc_bus_top soc_bus_sva u_sva (.*);

// File: sim/soc_bus_tb.sv
// system bus testbench driving a table of transfers on both masters against a model
`include "soc_bus_cfg.svh"

module soc_bus_tb;

   localparam int RAM_AW = $clog2(`RAM_WORDS);

   typedef struct packed {
      logic                 mst;   // 0 data port, 1 debug port
      logic                 we;
      logic [`SB_ADR_W-1:0] adr;
      logic [`SB_DAT_W-1:0] dat;
      logic [`SB_SEL_W-1:0] sel;
      logic [`SB_DAT_W-1:0] exp_dat;
      logic                 exp_err;
      logic                 conc;  // issued together with the next entry
   } entry_t;

   logic                 wb_clk;
   logic                 rst_n;
   logic [`SB_ADR_W-1:0] m_adr  [2];
   logic [`SB_DAT_W-1:0] m_wdat [2];
   logic [`SB_SEL_W-1:0] m_sel  [2];
   logic                 m_we   [2];
   logic                 m_cyc  [2];
   logic                 m_stb  [2];
   logic [`SB_DAT_W-1:0] m_rdat [2];
   logic                 m_ack  [2];
   logic                 m_err  [2];

   entry_t               tbl [$];
   logic [`SB_DAT_W-1:0] ram_model [0:`RAM_WORDS-1];
   int                   done_at [0:63];
   int                   done_cnt;
   logic                 last_mst; // master that finished last
   int                   errors;
   int                   checks;
   logic                 tbl_ready;

   tb_clk_gen u_clk (
      .clk_o   (wb_clk),
      .rst_n_o (rst_n)
   );

   soc_bus_top UUT (
      .wb_clk   (wb_clk),
      .rst_n_i  (rst_n),
      .m0_adr_i (m_adr[0]),
      .m0_dat_i (m_wdat[0]),
      .m0_sel_i (m_sel[0]),
      .m0_we_i  (m_we[0]),
      .m0_cyc_i (m_cyc[0]),
      .m0_stb_i (m_stb[0]),
      .m0_dat_o (m_rdat[0]),
      .m0_ack_o (m_ack[0]),
      .m0_err_o (m_err[0]),
      .m1_adr_i (m_adr[1]),
      .m1_dat_i (m_wdat[1]),
      .m1_sel_i (m_sel[1]),
      .m1_we_i  (m_we[1]),
      .m1_cyc_i (m_cyc[1]),
      .m1_stb_i (m_stb[1]),
      .m1_dat_o (m_rdat[1]),
      .m1_ack_o (m_ack[1]),
      .m1_err_o (m_err[1])
   );

   // random word in the ram region where the slot keeps the low index bits apart
   function automatic logic [`SB_ADR_W-1:0] ram_addr(input int slot);
      logic [31:0] r;
      r = $urandom;
      return {`RAM_REGION, r[23:12], r[4:0], slot[4:0], 2'b00};
   endfunction

   // appends one entry with its expectation from the address map
   function automatic void add(input logic mst, input logic we,
                               input logic [`SB_ADR_W-1:0] adr,
                               input logic [`SB_DAT_W-1:0] dat,
                               input logic [`SB_SEL_W-1:0] sel, input logic conc);
      entry_t            e;
      logic [RAM_AW-1:0] w;
      e = '{mst, we, adr, dat, sel, '0, 1'b0, conc};
      w = adr[RAM_AW+1:2];
      case (adr[`SB_ADR_W-1 -: 8])
         `RAM_REGION: begin
            for (int b = 0; b < `SB_SEL_W; b++)
               if (we && sel[b])
                  ram_model[w][8*b +: 8] = dat[8*b +: 8];
            e.exp_dat = ram_model[w];
         end
         `ROM_REGION: e.exp_dat = `ROM_WORD_BASE | 32'(adr[6:2]);
         `DS1_REGION: e.exp_dat = `DS1_VALUE;
         `DS2_REGION: e.exp_dat = `DS2_VALUE;
         `ETH_REGION: e.exp_dat = '0;
         default:     e.exp_err = 1'b1;
      endcase
      tbl.push_back(e);
   endfunction

   task automatic run_entry(input int k);
      entry_t e;
      int     m;
      e = tbl[k];
      m = int'(e.mst);
      m_adr[m]  = e.adr;
      m_wdat[m] = e.dat;
      m_sel[m]  = e.sel;
      m_we[m]   = e.we;
      m_cyc[m]  = 1'b1;
      m_stb[m]  = 1'b1;
      @(negedge wb_clk);
      while (!(m_ack[m] || m_err[m]))
         @(negedge wb_clk);
      checks++;
      if (m_err[m] !== e.exp_err) begin
         $display("CHECK FAILED t=%0t m%0d_err_o exp=%b got=%b", $time, m, e.exp_err, m_err[m]);
         errors++;
      end
      if (m_ack[m] !== !e.exp_err) begin
         $display("CHECK FAILED t=%0t m%0d_ack_o exp=%b got=%b", $time, m, !e.exp_err, m_ack[m]);
         errors++;
      end
      if (!e.we && !e.exp_err && m_rdat[m] !== e.exp_dat) begin
         $display("CHECK FAILED t=%0t m%0d_dat_o exp=%h got=%h", $time, m, e.exp_dat, m_rdat[m]);
         errors++;
      end
      m_cyc[m] = 1'b0; // adr and data stay while the strobes drop
      m_stb[m] = 1'b0;
      done_at[k] = done_cnt;
      done_cnt++;
      last_mst = e.mst;
   endtask

   initial begin
      logic [`SB_ADR_W-1:0] a [8];
      logic [`SB_SEL_W-1:0] lanes [3];
      logic                 prev;
      logic                 first;
      int                   k;
      errors    = 0;
      checks    = 0;
      done_cnt  = 0;
      last_mst  = 1'b1;
      tbl_ready = 1'b0;
      for (int i = 0; i < 2; i++) begin
         m_adr[i]  = '0;
         m_wdat[i] = '0;
         m_sel[i]  = '0;
         m_we[i]   = 1'b0;
         m_cyc[i]  = 1'b0;
         m_stb[i]  = 1'b0;
      end
      void'($urandom(32'hdcda067f));
      lanes = '{4'b0101, 4'b1000, 4'b0110};

      // full words read back through the other master
      for (int i = 0; i < 4; i++) begin
         a[i] = ram_addr(i);
         add(i[0], 1'b1, a[i], $urandom, 4'hf, 1'b0);
      end
      for (int i = 0; i < 4; i++)
         add(!i[0], 1'b0, a[i], '0, 4'hf, 1'b0);
      // byte lanes
      for (int i = 0; i < 3; i++) begin
         a[4] = ram_addr(4 + i);
         add(1'b0, 1'b1, a[4], $urandom, 4'hf, 1'b0);
         add(1'b1, 1'b1, a[4], $urandom, lanes[i], 1'b0);
         add(1'b0, 1'b0, a[4], '0, 4'hf, 1'b0);
      end
      add(1'b1, 1'b0, {`ROM_REGION, 17'd0, 5'd0, 2'b00}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b0, {`ROM_REGION, 17'd0, 5'd5, 2'b00}, '0, 4'hf, 1'b0);
      add(1'b1, 1'b0, {`ROM_REGION, 17'd0, 5'd31, 2'b00}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b0, {`DS1_REGION, 24'h000010}, '0, 4'hf, 1'b0);
      add(1'b1, 1'b0, {`DS2_REGION, 24'h000104}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b1, {`DS1_REGION, 24'h000000}, $urandom, 4'hf, 1'b0);
      add(1'b1, 1'b0, {`ETH_REGION, 24'h000020}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b1, {`ETH_REGION, 24'h000020}, $urandom, 4'hf, 1'b0);
      add(1'b1, 1'b0, {`ETH_REGION, 24'h000020}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b0, 32'h4000_0000, '0, 4'hf, 1'b0); // hole in the map
      add(1'b1, 1'b1, 32'h4000_1234, $urandom, 4'hf, 1'b0);
      // contention pairs on distinct words so order does not matter
      for (int p = 0; p < 3; p++) begin
         a[6] = ram_addr(8 + 2*p);
         a[7] = ram_addr(9 + 2*p);
         add(1'b0, 1'b1, a[6], $urandom, 4'hf, 1'b1);
         add(1'b1, 1'b1, a[7], $urandom, 4'hf, 1'b0);
         add(1'b0, 1'b0, a[7], '0, 4'hf, 1'b1);
         add(1'b1, 1'b0, a[6], '0, 4'hf, 1'b0);
      end
      // data port served last so the debug port takes the next tie
      add(1'b0, 1'b0, {`DS2_REGION, 24'h000008}, '0, 4'hf, 1'b0);
      add(1'b0, 1'b0, {`ROM_REGION, 17'd0, 5'd7, 2'b00}, '0, 4'hf, 1'b1);
      add(1'b1, 1'b0, 32'h4000_0010, '0, 4'hf, 1'b0);
      tbl_ready = 1'b1;

      wait (rst_n === 1'b1);
      @(negedge wb_clk);
      k = 0;
      while (k < tbl.size()) begin
         if (tbl[k].conc && k + 1 < tbl.size()) begin
            prev = last_mst;
            fork
               run_entry(k);
               run_entry(k + 1);
            join
            first = (done_at[k] < done_at[k+1]) ? tbl[k].mst : tbl[k+1].mst;
            if (first == prev) begin
               $display("arbiter served master %0d twice in a row at t=%0t", first, $time);
               errors++;
            end
            k += 2;
         end else begin
            run_entry(k);
            k++;
         end
         @(negedge wb_clk); // idle cycle between transfers
      end

      $display("soc_bus_tb: %0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // watchdog at 20 cycles per entry
   initial begin
      wait (tbl_ready === 1'b1);
      #(tbl.size() * 20 * 100);
      $display("timeout: the table of %0d entries did not finish", tbl.size());
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: soc_bus.f
+incdir+source
source/soc_bus_pkg.sv
source/wb_if.sv
source/wb_arbiter.sv
source/wb_decoder.sv
source/boot_rom.sv
source/wb_ram.sv
source/const_slave.sv
source/soc_bus_top.sv
sim/tb_clk_gen.sv
sim/soc_bus_sva.sv
sim/soc_bus_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = soc_bus_tb
FLIST = soc_bus.f
LOG   = sim.log

.PHONY: run clean

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
